// File: logic/lsxp_pkg.sv
`default_nettype none

package lsxp_pkg;

    localparam int addr_width    = 32;
    localparam int data_width    = 32;
    localparam int strb_width    = data_width / 8;
    localparam int no_slvs       = 8;
    localparam int slv_sel_width = 3;
    localparam int region_bits   = 10;  // 1 KiB per slave.
    localparam int unmapped_bits = addr_width - slv_sel_width - region_bits;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [strb_width-1:0] strb_t;
    typedef logic [2:0]            prot_t;
    typedef logic [1:0]            resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;
    localparam resp_t resp_decerr = 2'b11;

    // front end states.
    localparam logic [1:0] st_idle   = 2'd0;
    localparam logic [1:0] st_busy   = 2'd1;
    localparam logic [1:0] st_resp   = 2'd2;
    localparam logic [1:0] st_paused = 2'd3;

    // apb master states.
    localparam logic [1:0] ap_idle   = 2'd0;
    localparam logic [1:0] ap_setup  = 2'd1;
    localparam logic [1:0] ap_access = 2'd2;

    // one address word, seen raw or split into map fields
    typedef union packed {
        addr_t raw;
        struct packed {
            logic [unmapped_bits-1:0] unmapped;  // must be zero.
            logic [slv_sel_width-1:0] slv_idx;
            logic [region_bits-1:0]   offset;
        } fields;
    } lsxp_addr_u;

endpackage

`default_nettype wire

// File: logic/lsxp_xfer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lsxp_xfer_if import lsxp_pkg::*; ();

    logic  start;  // one cycle pulse.
    logic  write;
    addr_t addr;
    prot_t prot;
    data_t wdata;
    strb_t strb;
    logic  done;   // one cycle pulse, carries rdata and resp.
    data_t rdata;
    resp_t resp;

    modport front (
        output start, write, addr, prot, wdata, strb,
        input  done, rdata, resp
    );

    modport apb (
        input  start, write, addr, prot, wdata, strb,
        output done, rdata, resp
    );

endinterface

`default_nettype wire

// File: logic/lsxp_axil_front.sv
`timescale 1ns/1ps
`default_nettype none

module lsxp_axil_front import lsxp_pkg::*; (
    input  logic       seq,
    input  logic       reset,

    input  logic       pause_req,
    output logic       pause_ack,

    input  addr_t      awaddr,
    input  prot_t      awprot,
    input  logic       awvalid,
    output logic       awready,

    input  data_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,

    output resp_t      bresp,
    output logic       bvalid,
    input  logic       bready,

    input  addr_t      araddr,
    input  prot_t      arprot,
    input  logic       arvalid,
    output logic       arready,

    output data_t      rdata,
    output resp_t      rresp,
    output logic       rvalid,
    input  logic       rready,

    lsxp_xfer_if.front xfer
);

    logic [1:0] state;
    logic       last_read;   // last served was a read.
    logic       wr_pend;
    logic       can_accept;
    logic       take_wr;
    logic       take_rd;
    logic       start_q;

    lsxp_addr_u addr_q;
    logic       write_q;
    prot_t      prot_q;
    data_t      wdata_q;
    strb_t      strb_q;
    data_t      rdata_q;
    resp_t      resp_q;

    assign wr_pend    = awvalid && wvalid;  // aw and w together.
    assign can_accept = (state == st_idle) && !pause_req && !pause_ack;

    // alternate when both sides wait.
    assign take_wr = can_accept && wr_pend && (!arvalid || last_read);
    assign take_rd = can_accept && arvalid && !(wr_pend && last_read);

    assign awready = take_wr;
    assign wready  = take_wr;
    assign arready = take_rd;

    assign bresp = resp_q;
    assign rresp = resp_q;
    assign rdata = rdata_q;

    assign xfer.start = start_q;
    assign xfer.write = write_q;
    assign xfer.addr  = addr_q.raw;
    assign xfer.prot  = prot_q;
    assign xfer.wdata = wdata_q;
    assign xfer.strb  = strb_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            state     <= st_idle;
            last_read <= 1'b0;
            start_q   <= 1'b0;
            bvalid    <= 1'b0;
            rvalid    <= 1'b0;
            pause_ack <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (take_wr || take_rd) begin
                        state     <= st_busy;
                        start_q   <= 1'b1;
                        last_read <= take_rd;
                    end else if (pause_req) begin
                        state     <= st_paused;  // only from idle.
                        pause_ack <= 1'b1;
                    end
                end
                st_busy: begin
                    if (xfer.done) begin
                        state  <= st_resp;
                        bvalid <= write_q;
                        rvalid <= !write_q;
                    end
                end
                st_resp: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state  <= st_idle;
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                    end
                end
                st_paused: begin
                    if (!pause_req) begin
                        state     <= st_idle;
                        pause_ack <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if (take_wr) begin
            addr_q.raw <= awaddr;
            prot_q     <= awprot;
            wdata_q    <= wdata;
            strb_q     <= wstrb;
            write_q    <= 1'b1;
        end else if (take_rd) begin
            addr_q.raw <= araddr;
            prot_q     <= arprot;
            write_q    <= 1'b0;
        end
        if ((state == st_busy) && xfer.done) begin
            rdata_q <= xfer.rdata;  // held for b or r.
            resp_q  <= xfer.resp;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsxp_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module lsxp_apb_master import lsxp_pkg::*; (
    input  logic                seq,
    input  logic                reset,

    output addr_t               paddr,
    output prot_t               pprot,
    output logic                pwrite,
    output data_t               pwdata,
    output strb_t               pstrb,
    output logic                penable,
    output logic [no_slvs-1:0]  psel,
    input  data_t [no_slvs-1:0] prdata,
    input  logic [no_slvs-1:0]  pready,
    input  logic [no_slvs-1:0]  pslverr,

    lsxp_xfer_if.apb            xfer
);

    logic [1:0]               state;
    lsxp_addr_u               addr_dec;
    logic                     unmapped;
    logic [slv_sel_width-1:0] idx;
    logic                     sel_ready;
    data_t                    sel_rdata;
    logic                     sel_err;
    logic                     done_q;
    data_t                    rdata_q;
    resp_t                    resp_q;

    // payload is stable from start to done.
    assign addr_dec.raw = xfer.addr;
    assign unmapped     = |addr_dec.fields.unmapped;
    assign idx          = addr_dec.fields.slv_idx;

    assign sel_ready = pready[idx];
    assign sel_rdata = prdata[idx];
    assign sel_err   = pslverr[idx];

    assign paddr   = xfer.addr;
    assign pprot   = xfer.prot;
    assign pwrite  = xfer.write;
    assign pwdata  = xfer.wdata;
    assign pstrb   = xfer.write ? xfer.strb : '0;  // apb4 wants zero on reads.
    assign penable = (state == ap_access);

    always_comb begin
        psel = '0;
        if (state != ap_idle) begin
            psel[idx] = 1'b1;
        end
    end

    assign xfer.done  = done_q;
    assign xfer.rdata = rdata_q;
    assign xfer.resp  = resp_q;

    always_ff @(posedge seq) begin
        if (reset) begin
            state  <= ap_idle;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ap_idle: begin
                    if (xfer.start) begin
                        if (unmapped) begin
                            done_q <= 1'b1;  // decode error, no select.
                        end else begin
                            state <= ap_setup;
                        end
                    end
                end
                ap_setup: begin
                    state <= ap_access;
                end
                ap_access: begin
                    if (sel_ready) begin
                        state  <= ap_idle;
                        done_q <= 1'b1;
                    end
                end
                default: state <= ap_idle;
            endcase
        end
    end

    always_ff @(posedge seq) begin
        if ((state == ap_idle) && xfer.start && unmapped) begin
            rdata_q <= '0;
            resp_q  <= resp_decerr;
        end else if ((state == ap_access) && sel_ready) begin
            rdata_q <= sel_rdata;
            resp_q  <= sel_err ? resp_slverr : resp_okay;
        end
    end

endmodule

`default_nettype wire

// File: logic/lsxp_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module lsxp_fabric import lsxp_pkg::*; (
    input  logic                seq,
    input  logic                reset,

    input  logic                pause_req,
    output logic                pause_ack,

    input  addr_t               awaddr,
    input  prot_t               awprot,
    input  logic                awvalid,
    output logic                awready,
    input  data_t               wdata,
    input  strb_t               wstrb,
    input  logic                wvalid,
    output logic                wready,
    output resp_t               bresp,
    output logic                bvalid,
    input  logic                bready,
    input  addr_t               araddr,
    input  prot_t               arprot,
    input  logic                arvalid,
    output logic                arready,
    output data_t               rdata,
    output resp_t               rresp,
    output logic                rvalid,
    input  logic                rready,

    output addr_t               paddr,
    output prot_t               pprot,
    output logic                pwrite,
    output data_t               pwdata,
    output strb_t               pstrb,
    output logic                penable,
    output logic [no_slvs-1:0]  psel,
    input  data_t [no_slvs-1:0] prdata,
    input  logic [no_slvs-1:0]  pready,
    input  logic [no_slvs-1:0]  pslverr
);

    lsxp_xfer_if xfer ();  // one transfer at a time.

    lsxp_axil_front u_front (
        .seq       (seq),
        .reset     (reset),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .xfer      (xfer.front)
    );

    lsxp_apb_master u_apb (
        .seq     (seq),
        .reset   (reset),
        .paddr   (paddr),
        .pprot   (pprot),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .penable (penable),
        .psel    (psel),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .xfer    (xfer.apb)
    );

endmodule

`default_nettype wire

// File: testbench/lsxp_fabric_checker.sv
`timescale 1ns/1ps
`default_nettype none

module lsxp_fabric_checker import lsxp_pkg::*; (
    input logic               seq,
    input logic               reset,
    input logic               pause_ack,
    input logic               bvalid,
    input logic               bready,
    input logic               rvalid,
    input logic               rready,
    input logic               penable,
    input logic [no_slvs-1:0] psel
);

    penable_onehot: assert property (@(posedge seq) disable iff (reset)
        penable |-> $onehot(psel))
        else $error("penable high without exactly one psel");

    // setup cycle leads into access on the same slave.
    setup_then_access: assert property (@(posedge seq) disable iff (reset)
        ((|psel) && !penable) |=> (penable && $stable(psel)))
        else $error("psel setup not followed by penable");

    bvalid_held: assert property (@(posedge seq) disable iff (reset)
        (bvalid && !bready) |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge seq) disable iff (reset)
        (rvalid && !rready) |=> rvalid)
        else $error("rvalid dropped before rready");

    paused_quiet: assert property (@(posedge seq) disable iff (reset)
        pause_ack |-> (psel == '0))
        else $error("psel raised while paused");

endmodule

bind lsxp_fabric lsxp_fabric_checker u_checker (.*);

`default_nettype wire

// File: testbench/lsxp_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsxp_fabric_tb import lsxp_pkg::*; ();

    localparam int unsigned timeout_cycles = 200;

    typedef struct packed {
        logic  has_data;
        resp_t exp_resp;
        resp_t act_resp;
        data_t exp_data;
        data_t act_data;
    } result_t;

    logic  seq = 1'b0;
    logic  reset;
    logic  pause_req;
    logic  pause_ack;
    addr_t awaddr, araddr, paddr;
    prot_t awprot, arprot, pprot;
    data_t wdata, rdata, pwdata;
    strb_t wstrb, pstrb;
    resp_t bresp, rresp;
    logic  awvalid, wvalid, bready, arvalid, rready;
    logic  awready, wready, bvalid, arready, rvalid, pwrite, penable;
    logic  [no_slvs-1:0] psel;
    logic  [no_slvs-1:0] pready = '0;
    logic  [no_slvs-1:0] pslverr = '0;
    data_t [no_slvs-1:0] prdata = '0;

    data_t       slv_mem [no_slvs][256];
    data_t       shadow [no_slvs][256];
    int unsigned wait_cnt [no_slvs];
    int unsigned psel_cycles = 0;
    result_t     results[$];
    string       names[$];
    string       cur_name = "";
    prot_t       cur_prot = '0;

    lsxp_fabric u_dut (.*);

    initial begin
        forever #2 seq = ~seq;
    end

    function automatic data_t fill_word(int s, int w);
        return 32'h5a5a_0000 ^ ((s * 256 + w) * 32'h9e37_79b1);
    endfunction

    // shadow model of the whole address map.
    function automatic resp_t exp_result(logic is_write, addr_t addr, data_t wd, strb_t st,
                                         output data_t exp_data);
        logic [2:0] s;
        logic [7:0] w;
        exp_data = '0;
        s = addr[12:10];
        w = addr[9:2];
        if (addr[addr_width-1:slv_sel_width+region_bits] != '0) begin
            return resp_decerr;
        end
        if (s == 3'd7 && addr[9]) begin
            return resp_slverr;  // upper half of slave 7.
        end
        if (is_write) begin
            for (int b = 0; b < strb_width; b++) begin
                if (st[b]) begin
                    shadow[s][w][8*b +: 8] = wd[8*b +: 8];
                end
            end
        end
        exp_data = shadow[s][w];
        return resp_okay;
    endfunction

    task automatic stop_run(string why);
        if (why != "") begin
            $display("%s", why);
        end
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_resp(string name, resp_t exp, resp_t act);
        if (act !== exp) begin
            $display("error %s: expected resp %0d, actual resp %0d", name, exp, act);
            stop_run("");
        end
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (act !== exp) begin
            $display("error %s: expected data %08h, actual data %08h", name, exp, act);
            stop_run("");
        end
    endtask

    task automatic check_prot(string name, prot_t exp, prot_t act);
        if (act !== exp) begin
            $display("error %s: expected pprot %0d, actual pprot %0d", name, exp, act);
            stop_run("");
        end
    endtask

    function automatic logic probe(string what);
        case (what)
            "aw and w ready":   return awready && wready;
            "arready":          return arready;
            "bvalid":           return bvalid;
            "rvalid":           return rvalid;
            "pause_ack":        return pause_ack;
            "pause_ack low":    return !pause_ack;
            "results drained":  return results.size() == 0;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic wait_until(string what);
        int unsigned n;
        n = 0;
        do begin
            @(negedge seq);
            n++;
            if (n > timeout_cycles) begin
                stop_run($sformatf("timeout while waiting for %s", what));
            end
        end while (!probe(what));
    endtask

    // random stall before taking b or r.
    task automatic accept_response(logic is_write, output resp_t resp, output data_t data);
        wait_until(is_write ? "bvalid" : "rvalid");
        repeat ($urandom_range(0, 2)) @(posedge seq);
        @(posedge seq);
        bready <= is_write;
        rready <= !is_write;
        @(negedge seq);
        resp = is_write ? bresp : rresp;
        data = rdata;
        @(posedge seq);
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic run_txn(string name, logic is_write, addr_t addr, data_t d, strb_t st);
        result_t r;
        data_t   exp_data;
        resp_t   act_resp;
        data_t   act_data;
        prot_t   p;
        r.exp_resp = exp_result(is_write, addr, d, st, exp_data);
        p = prot_t'($urandom);
        cur_name = name;
        cur_prot = p;  // pprot carries it unchanged.
        @(posedge seq);
        if (is_write) begin
            awaddr  <= addr;
            awprot  <= p;
            wdata   <= d;
            wstrb   <= st;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            araddr  <= addr;
            arprot  <= p;
            arvalid <= 1'b1;
        end
        wait_until(is_write ? "aw and w ready" : "arready");
        @(posedge seq);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        accept_response(is_write, act_resp, act_data);
        r.has_data = !is_write && (r.exp_resp == resp_okay);
        r.exp_data = exp_data;
        r.act_resp = act_resp;
        r.act_data = act_data;
        results.push_back(r);
        names.push_back(name);
    endtask

    always @(posedge seq) begin : apb_slaves
        logic       err;
        logic [7:0] w;
        w = paddr[9:2];
        err = psel[7] && paddr[9];  // slave 7 upper half.
        if (reset) begin
            pready  <= '0;
            pslverr <= '0;
            for (int s = 0; s < no_slvs; s++) begin
                for (int i = 0; i < 256; i++) begin
                    slv_mem[s][i] = fill_word(s, i);
                end
            end
        end else begin
            for (int s = 0; s < no_slvs; s++) begin
                pready[s]  <= 1'b0;
                pslverr[s] <= 1'b0;
                if (psel[s] && !penable) begin
                    check_prot(cur_name, cur_prot, pprot);
                    wait_cnt[s] = $urandom_range(0, 3);
                end else if (psel[s] && !pready[s]) begin
                    if (wait_cnt[s] != 0) begin
                        wait_cnt[s] = wait_cnt[s] - 1;
                    end else begin
                        pready[s]  <= 1'b1;
                        pslverr[s] <= err;
                        prdata[s]  <= err ? '0 : slv_mem[s][w];
                        for (int b = 0; b < strb_width; b++) begin
                            if (pwrite && !err && pstrb[b]) begin
                                slv_mem[s][w][8*b +: 8] = pwdata[8*b +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

    always @(negedge seq) begin : watch_bus
        if (!reset) begin
            if (|psel) begin
                psel_cycles++;
            end
            if (pause_ack && (awready || arready || bvalid || rvalid || (|psel))) begin
                stop_run("a transfer moved while pause was acknowledged");
            end
        end
    end

    always @(negedge seq) begin : compare_results
        result_t r;
        string   n;
        while (results.size() > 0) begin
            r = results.pop_front();
            n = names.pop_front();
            check_resp(n, r.exp_resp, r.act_resp);
            if (r.has_data) begin
                check_data(n, r.exp_data, r.act_data);
            end
        end
    end

    initial begin
        addr_t       a;
        int unsigned base;
        void'($urandom(32'hca4b6e11));
        for (int s = 0; s < no_slvs; s++) begin
            for (int i = 0; i < 256; i++) begin
                shadow[s][i] = fill_word(s, i);
            end
        end
        reset = 1'b1;
        pause_req = 1'b0;
        awaddr = '0;
        awprot = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arprot = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (5) @(posedge seq);
        reset <= 1'b0;

        for (int s = 0; s < no_slvs; s++) begin
            for (int e = 0; e < 2; e++) begin
                a = addr_t'(s << region_bits) + e * 32'h3fc;  // first and last word.
                run_txn($sformatf("edge write s%0d", s), 1'b1, a, $urandom, 4'hf);
                run_txn($sformatf("edge read s%0d", s), 1'b0, a, '0, '0);
            end
        end
        for (int k = 0; k < 16; k++) begin
            run_txn("strobe write", 1'b1, 32'h0000_0444, $urandom, strb_t'(k));
            run_txn("strobe read", 1'b0, 32'h0000_0444, '0, '0);
        end

        base = psel_cycles;
        run_txn("decode write", 1'b1, 32'h0001_0000, 32'h1234_5678, 4'hf);
        run_txn("decode read", 1'b0, 32'h8000_0004, '0, '0);
        if (psel_cycles != base) begin
            stop_run("psel rose for an unmapped address");
        end
        run_txn("slverr write", 1'b1, 32'h0000_1e00, 32'hdead_beef, 4'hf);
        run_txn("slverr read", 1'b0, 32'h0000_1e00, '0, '0);
        run_txn("slave 7 lower read", 1'b0, 32'h0000_1dfc, '0, '0);

        // pause lands while a read is in flight.
        fork
            run_txn("read before pause", 1'b0, 32'h0000_0c00, '0, '0);
            begin
                repeat (3) @(posedge seq);
                pause_req <= 1'b1;
            end
        join
        wait_until("pause_ack");
        fork
            begin
                repeat (12) @(posedge seq);
                pause_req <= 1'b0;
                wait_until("pause_ack low");
            end
            run_txn("write held by pause", 1'b1, 32'h0000_0810, 32'hfeed_0123, 4'hf);
        join
        run_txn("read after pause", 1'b0, 32'h0000_0810, '0, '0);

        repeat (300) begin
            a = {($urandom_range(0, 9) == 0) ? 19'h1 : 19'h0, 3'($urandom), 8'($urandom),
                 2'b00};
            run_txn("random", ($urandom % 2) == 1, a, $urandom, strb_t'($urandom));
        end
        wait_until("results drained");
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
logic/lsxp_pkg.sv
logic/lsxp_xfer_if.sv
logic/lsxp_axil_front.sv
logic/lsxp_apb_master.sv
logic/lsxp_fabric.sv
testbench/lsxp_fabric_checker.sv
testbench/lsxp_fabric_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module lsxp_fabric_tb -Mdir "$build_dir" -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/Vlsxp_fabric_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$log_file"; then
    exit 0
else
    echo "pass line not found in $log_file"
    exit 1
fi
